// ==== Makefile ====
SRCS := $(shell cat list.f)

.PHONY: run clean

run: obj_dir/Vtb_residue
	./obj_dir/Vtb_residue

obj_dir/Vtb_residue: list.f $(SRCS)
	verilator --binary --timing --assert -f list.f --top-module tb_residue -o Vtb_residue

clean:
	rm -rf obj_dir

// ==== dv/residue_stim.txt ====
// columns: word 0, word 1, word 2 (word 0 most significant), idle cycles before
// each of the three words, expected residue of the 300-bit operand modulo 53.
0 0 0 0 0 0 0
FFFFFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFFFFFFF 0 0 0 2D
0 0 34 1 0 0 34
0 0 35 0 2 0 0
0 1 2B 0 0 1 0
1 0 6 2 0 0 0
1 1 1 0 1 0 5
8000000000000000000000000 5555555555555555555555555 AAAAAAAAAAAAAAAAAAAAAAAAA 0 0 0 6
F000000000000000000000000 FFFFFFFFFFFF 123 1 1 0 14
1000000000000000000000000 1000000000000 ABC 0 0 0 16
FFFF 3E8 100 0 3 2 18
FFFFFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFFFFFFF FFFFFFFFFFFFFFFFFFFFFFFFF 2 5 1 2D
8000000000000000000000000 5555555555555555555555555 AAAAAAAAAAAAAAAAAAAAAAAAA 3 0 4 6
1000000000000000000000000 1000000000000 ABC 1 1 1 16
5555555555555555555555555 AAAAAAAAAAAAAAAAAAAAAAAAA FFFF 0 0 0 10
34 34 34 4 0 2 30

// ==== dv/tb_residue.sv ====
`timescale 1ns/1ns

module tb_residue;

  localparam int WORDS   = 3;
  localparam int RECORDS = 16;
  localparam int FIELDS  = 7;   // three words, three gap counts, expected residue.

  logic                clk = 1'b0;
  logic                rst_n;
  logic                start;
  logic                word_valid;
  mod53_pkg::word_t    word;
  logic                busy;
  logic                done;
  mod53_pkg::residue_t residue;

  logic [99:0] stim [0:RECORDS*FIELDS-1];
  int          watch_cycles = 0;
  int          done_count = 0;

  residue_top #(
    .WORDS (WORDS)
  ) dut
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .word_valid (word_valid),
    .word       (word),
    .busy       (busy),
    .done       (done),
    .residue    (residue)
  );

  always #4 clk = ~clk;

  // counts every done pulse, so a stray one shows up at the next result.
  always @(posedge clk)
  begin
    if (done)
      done_count++;
  end

  task automatic compare(input string name, input logic [31:0] got,
                         input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, expected);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  function automatic mod53_pkg::word_t random_word();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] d;

    a = $urandom;
    b = $urandom;
    c = $urandom;
    d = $urandom;
    return {a[3:0], b, c, d};
  endfunction

  // inputs change right after the rising edge and hold for one cycle.
  task automatic drive_cycle(input logic st, input logic valid, input mod53_pkg::word_t w);
    @(posedge clk);
    start      <= st;
    word_valid <= valid;
    word       <= w;
  endtask

  initial
  begin
    int          base;
    int          gap;
    int          gap_sum;
    int          max_gap;
    int          latency;
    logic [31:0] expected;

    rst_n      <= 1'b0;
    start      <= 1'b0;
    word_valid <= 1'b0;
    word       <= '0;
    void'($urandom(32'h4450_73a8));

    $readmemh("dv/residue_stim.txt", stim);
    if ($isunknown(stim[RECORDS*FIELDS-1]))
    begin
      $display("the stim file is missing or holds too few records");
      $display("tests failed");
      $fatal(1);
    end

    max_gap = 0;
    for (int r = 0; r < RECORDS; r++)
    begin
      gap_sum = int'(stim[r*FIELDS+3]) + int'(stim[r*FIELDS+4]) + int'(stim[r*FIELDS+5]);
      if (gap_sum > max_gap)
        max_gap = gap_sum;
    end
    watch_cycles = RECORDS * (WORDS + max_gap + 10) + 100;

    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // stray words before the first start must leave the DUT quiet.
    for (int i = 0; i < 4; i++)
    begin
      drive_cycle(1'b0, 1'b1, random_word());
      @(negedge clk);
      compare("busy", 32'(busy), 32'd0);
      compare("done", 32'(done), 32'd0);
      compare("residue", 32'(residue), 32'd0);
    end

    for (int r = 0; r < RECORDS; r++)
    begin
      base     = r * FIELDS;
      expected = 32'(stim[base+6]);

      repeat ($urandom % 3)
        drive_cycle(1'b0, 1'b1, random_word());   // dropped while idle.
      drive_cycle(1'b1, 1'b0, '0);

      for (int w = 0; w < WORDS; w++)
      begin
        gap = int'(stim[base+3+w]);
        for (int g = 0; g < gap; g++)
          drive_cycle(1'b0, 1'b0, '0);
        drive_cycle(w == 1, 1'b1, stim[base+w]);   // a start while busy must be ignored.
      end
      drive_cycle(1'b0, 1'b0, '0);   // this edge samples the last word.

      latency = 0;
      do
      begin
        @(negedge clk);
        latency++;
        if (!done)
          compare("busy", 32'(busy), 32'd1);
      end
      while (!done && latency < 20);

      if (!done)
      begin
        $display("no done pulse came for record %0d", r);
        $display("tests failed");
        $fatal(1);
      end
      compare("done latency", 32'(latency), 32'd3);
      compare("done count", 32'(done_count), 32'(r));
      compare("residue", 32'(residue), expected);
      compare("busy", 32'(busy), 32'd0);

      // the result holds after done even with words arriving.
      for (int h = 0; h < 2; h++)
      begin
        drive_cycle(1'b0, 1'b1, random_word());
        @(negedge clk);
        compare("done", 32'(done), 32'd0);
        compare("busy", 32'(busy), 32'd0);
        compare("residue", 32'(residue), expected);
      end
    end

    $display("all tests passed");
    $finish;
  end

  initial
  begin
    wait (watch_cycles > 0);
    repeat (watch_cycles) @(posedge clk);
    $display("the run hung: no result within %0d cycles", watch_cycles);
    $display("tests failed");
    $fatal(1);
  end

endmodule

// ==== list.f ====
rtl/mod53_pkg.sv
rtl/chunk_residue.sv
rtl/residue_accum.sv
rtl/word_counter.sv
rtl/residue_ctrl.sv
rtl/residue_top.sv
dv/tb_residue.sv

// ==== rtl/chunk_residue.sv ====
`timescale 1ns/1ns

module chunk_residue
(
  input  logic               clk,
  input  logic               rst_n,
  input  logic               word_take,
  input  mod53_pkg::word_t   word,
  output mod53_pkg::residue_t word_res,
  output logic               res_valid
);

  mod53_pkg::residue_t chunk_res [0:16];
  logic [11:0]         prod [1:16];   // residue times weight, at most 52 * 52.
  logic [13:0]         group_sum [0:3];
  logic [15:0]         word_sum;
  logic [15:0]         fold_1;
  logic [15:0]         fold_2;
  logic [15:0]         fold_3;
  logic [15:0]         fold_4;
  logic [6:0]          fold_5;
  mod53_pkg::residue_t word_mod;

  // bits above bit 5 count 2^6 each, which is 11 mod 53.
  function automatic logic [15:0] fold64(input logic [15:0] x);
    fold64 = {10'd0, x[5:0]} + x[15:6] * 16'd11;
  endfunction

  // last fold on an 8-bit value with 2^6 as 11 and 2^7 as 22.
  function automatic logic [6:0] fold_top(input logic [7:0] x);
    fold_top = {1'b0, x[5:0]} + (x[6] ? 7'd11 : 7'd0) + (x[7] ? 7'd22 : 7'd0);
  endfunction

  // a 6-bit chunk is at most 63, so one subtraction brings it below 53.
  for (genvar i = 0; i < 16; i++)
  begin : g_chunk
    logic [5:0] raw;

    assign raw = word[6*i+1 +: 6];
    assign chunk_res[i] = (raw >= mod53_pkg::MODULUS) ? raw - mod53_pkg::MODULUS : raw;
  end

  assign chunk_res[16] = {2'b00, word[100:97]};  // only 4 bits, already below 53.

  for (genvar i = 1; i <= 16; i++)
  begin : g_prod
    assign prod[i] = 12'(chunk_res[i]) * 12'(mod53_pkg::CHUNK_WEIGHT[i]);
  end

  always_comb
  begin
    for (int g = 0; g < 4; g++)
    begin
      group_sum[g] = 14'(prod[4*g+1]) + 14'(prod[4*g+2])
                   + 14'(prod[4*g+3]) + 14'(prod[4*g+4]);
    end
  end

  // at most 43316, so the sum fits in 16 bits.
  assign word_sum = 16'(group_sum[0]) + 16'(group_sum[1])
                  + 16'(group_sum[2]) + 16'(group_sum[3])
                  + 16'(chunk_res[0]);

  // The bound shrinks to 7499, 1350, 294 and 107 over the four wide folds.
  assign fold_1 = fold64(word_sum);
  assign fold_2 = fold64(fold_1);
  assign fold_3 = fold64(fold_2);
  assign fold_4 = fold64(fold_3);
  assign fold_5 = fold_top(fold_4[7:0]);   // at most 96 here.

  assign word_mod = (fold_5 >= {1'b0, mod53_pkg::MODULUS})
                  ? 6'(fold_5 - {1'b0, mod53_pkg::MODULUS})
                  : fold_5[5:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      res_valid <= 1'b0;
    else
      res_valid <= word_take;
  end

  always_ff @(posedge clk)
  begin
    if (word_take)
      word_res <= word_mod;
  end

  // a presented residue is always fully reduced.
  assert property (@(posedge clk) disable iff (!rst_n)
    res_valid |-> (word_res < mod53_pkg::MODULUS));

endmodule

// ==== rtl/mod53_pkg.sv ====
package mod53_pkg;

  // one operand word. Bit 100 is the most significant.
  typedef logic [100:1] word_t;

  // a residue modulo 53, always below 53.
  typedef logic [5:0] residue_t;

  // index of a word within an operand.
  typedef logic [15:0] count_t;

  localparam residue_t MODULUS = 6'd53;

  // Chunk i of a word covers bits 6i+6 down to 6i+1 and carries weight 2^(6i) mod 53.
  // Chunk 0 has weight 1 and needs no entry. Chunk 16 holds only bits 100 to 97.
  localparam residue_t CHUNK_WEIGHT [1:16] = '{
    6'd11, 6'd15, 6'd6,  6'd13, 6'd37, 6'd36, 6'd25, 6'd10,
    6'd4,  6'd44, 6'd7,  6'd24, 6'd52, 6'd42, 6'd38, 6'd47
  };

  // 2^100 mod 53, the step between successive words of an operand.
  localparam residue_t RADIX_WEIGHT = 6'd10;

  typedef enum logic [1:0]
  {
    ST_IDLE,
    ST_COLLECT,
    ST_FINISH
  } ctrl_state_t;

endpackage

// ==== rtl/residue_accum.sv ====
`timescale 1ns/1ns

module residue_accum
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                clear,
  input  logic                res_valid,
  input  mod53_pkg::residue_t word_res,
  output mod53_pkg::residue_t residue
);

  logic [9:0]          horner;   // residue * 10 + word_res, at most 572.
  logic [7:0]          fold_1;
  logic [6:0]          fold_2;
  mod53_pkg::residue_t acc_next;

  assign horner = 10'(residue) * 10'(mod53_pkg::RADIX_WEIGHT) + 10'(word_res);

  // 64 is 11 mod 53. The first fold leaves at most 151.
  assign fold_1 = {2'b00, horner[5:0]} + 8'(horner[9:6]) * 8'd11;

  // a second fold with 2^6 as 11 and 2^7 as 22 leaves at most 96.
  assign fold_2 = {1'b0, fold_1[5:0]}
                + (fold_1[6] ? 7'd11 : 7'd0)
                + (fold_1[7] ? 7'd22 : 7'd0);

  assign acc_next = (fold_2 >= {1'b0, mod53_pkg::MODULUS})
                  ? 6'(fold_2 - {1'b0, mod53_pkg::MODULUS})
                  : fold_2[5:0];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      residue <= '0;
    else if (clear)
      residue <= '0;   // a new operand starts from zero.
    else if (res_valid)
      residue <= acc_next;
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    residue < mod53_pkg::MODULUS);

endmodule

// ==== rtl/residue_ctrl.sv ====
`timescale 1ns/1ns

module residue_ctrl
(
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic res_valid,
  input  logic last,
  output logic collect,
  output logic clear,
  output logic busy,
  output logic done
);

  mod53_pkg::ctrl_state_t state;
  mod53_pkg::ctrl_state_t state_next;

  always_comb
  begin
    state_next = state;
    case (state)
      mod53_pkg::ST_IDLE:
      begin
        if (start)
          state_next = mod53_pkg::ST_COLLECT;
      end
      mod53_pkg::ST_COLLECT:
      begin
        if (res_valid && last)
          state_next = mod53_pkg::ST_FINISH;   // final word is being accumulated.
      end
      mod53_pkg::ST_FINISH:
      begin
        state_next = mod53_pkg::ST_IDLE;
      end
      default:
      begin
        state_next = mod53_pkg::ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state <= mod53_pkg::ST_IDLE;
      done  <= 1'b0;
    end
    else
    begin
      state <= state_next;
      done  <= (state == mod53_pkg::ST_FINISH);   // rises as busy falls.
    end
  end

  // start is only honoured from idle.
  assign clear   = start && (state == mod53_pkg::ST_IDLE);
  assign collect = (state == mod53_pkg::ST_COLLECT);
  assign busy    = (state != mod53_pkg::ST_IDLE);

  assert property (@(posedge clk) disable iff (!rst_n)
    done |=> !done);

endmodule

// ==== rtl/residue_top.sv ====
`timescale 1ns/1ns

module residue_top
#(
  parameter int unsigned WORDS = 3
)
(
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  logic                word_valid,
  input  mod53_pkg::word_t    word,
  output logic                busy,
  output logic                done,
  output mod53_pkg::residue_t residue
);

  logic                collect;
  logic                clear;
  logic                word_take;
  logic                res_valid;
  logic                last;
  mod53_pkg::residue_t word_res;

  assign word_take = word_valid && collect;   // words outside an operand are dropped.

  chunk_residue u_chunk_residue
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .word_take (word_take),
    .word      (word),
    .word_res  (word_res),
    .res_valid (res_valid)
  );

  residue_accum u_residue_accum
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .res_valid (res_valid),
    .word_res  (word_res),
    .residue   (residue)
  );

  word_counter #(
    .WORDS (WORDS)
  ) u_word_counter
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (clear),
    .res_valid (res_valid),
    .last      (last)
  );

  residue_ctrl u_residue_ctrl
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .res_valid (res_valid),
    .last      (last),
    .collect   (collect),
    .clear     (clear),
    .busy      (busy),
    .done      (done)
  );

endmodule

// ==== rtl/word_counter.sv ====
`timescale 1ns/1ns

module word_counter
#(
  parameter int unsigned WORDS = 1
)
(
  input  logic clk,
  input  logic rst_n,
  input  logic clear,
  input  logic res_valid,
  output logic last
);

  localparam mod53_pkg::count_t LAST_INDEX = mod53_pkg::count_t'(WORDS - 1);

  mod53_pkg::count_t count;

  assign last = (count == LAST_INDEX);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      count <= '0;
    else if (clear)
      count <= '0;
    else if (res_valid)
    begin
      if (last)
        count <= '0;   // wrap so a stray word cannot run past the end.
      else
        count <= count + 1'b1;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    count <= LAST_INDEX);

endmodule
